//--- tb/endpoint_input.txt
# columns: op dstaddr srcaddr data expected_read_word expected_err_out (all hex)
# op 1 write, 0 read, anything else is dropped; word index is dstaddr[5:2]
1 00000000 00000000 11111111 00000000 0
1 00000004 00000000 22222222 00000000 0
1 00000008 00000000 33333333 00000000 0
1 0000000c 00000000 44444444 00000000 0
1 0000003c 00000000 a5a5a5a5 00000000 0
0 00000000 80000010 00000000 11111111 0
0 00000004 80000014 00000000 22222222 0
0 00000008 80000018 00000000 33333333 0
0 00000040 8000001c 00000000 11111111 0
0 0000007c 80000020 00000000 a5a5a5a5 0
1 00000104 00000000 5a5a0001 00000000 0
0 00000004 80000024 00000000 5a5a0001 0
7 0000000c 00000000 ffffffff 00000000 1
0 0000000c 80000028 00000000 44444444 1
2 00000008 00000000 0badf00d 00000000 1
0 00000008 8000002c 00000000 33333333 1
f 00000000 00000000 77777777 00000000 1
1 00000010 00000000 c3c3c3c3 00000000 1
0 00000050 80000030 00000000 c3c3c3c3 1
0 00000000 80000034 00000000 11111111 1

//--- all.f
common/emesh_pkg.sv
common/emesh_if.sv
packet/packet2emesh.sv
packet/emesh2packet.sv
logic/access_ctrl.sv
logic/wait_timer.sv
logic/reg_mem.sv
logic/emesh_endpoint.sv
tb/tb_emesh_endpoint.sv

//--- Makefile
# Verilator flow for the emesh endpoint, run from the project root
VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= tb_emesh_endpoint
RTL_TOP    ?= emesh_endpoint
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing -f $(FILELIST) --top-module $(RTL_TOP)

# the binary exits nonzero when the testbench stops with $$fatal
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- tb/tb_emesh_endpoint.sv
// PW 112 only; vectors come from tb/endpoint_input.txt, run from the project root
`default_nettype none

module tb_emesh_endpoint;
    import emesh_pkg::*;

    localparam int AW        = 32;
    localparam int PW        = 112;
    localparam int MEM_DEPTH = 16;
    localparam int READ_WAIT = 3;
    localparam int TIMEOUT   = 200;  // cycles per wait loop

    // held on packet_in while the endpoint is busy, must never land
    localparam logic [AW-1:0]     STRAY_ADDR = 32'h0000_0008;
    localparam logic [WORD_W-1:0] STRAY_DATA = 32'hdead_beef;

    logic          clk;
    logic          rst_n;
    logic          access_in;
    logic [PW-1:0] packet_in;
    logic          wait_out;
    logic          access_out;
    logic [PW-1:0] packet_out;
    logic          wait_in;
    logic          err_out;

    integer seed = 32'h8c7d_c674;

    emesh_endpoint #(
        .AW(AW), .PW(PW), .MEM_DEPTH(MEM_DEPTH), .READ_WAIT(READ_WAIT)
    ) emesh_endpoint_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .access_in  (access_in),
        .packet_in  (packet_in),
        .wait_out   (wait_out),
        .access_out (access_out),
        .packet_out (packet_out),
        .wait_in    (wait_in),
        .err_out    (err_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ########################################################################
    // failure reporting and compare tasks
    // ########################################################################
    task automatic stop_run();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        stop_run();
    endtask

    task automatic check_word(input string what, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_addr(input string what, input logic [AW-1:0] got,
                              input logic [AW-1:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_op(input string what, input emesh_op_e got, input emesh_op_e exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %h, expected %s", $time, what, got, exp.name());
            stop_run();
        end
    endtask

    task automatic check_level(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        if (got != exp) begin
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            stop_run();
        end
    endtask

    // ########################################################################
    // stimulus helpers, all called at a falling edge
    // ########################################################################
    // srcaddr and the low data word share bits 79:48 at this width
    function automatic logic [PW-1:0] build_packet(input logic [OP_W-1:0] op,
        input logic [AW-1:0] dst, input logic [AW-1:0] src, input logic [WORD_W-1:0] data);
        logic [AW-1:0] low;
        low = (op == OP_READ) ? src : data;
        return {32'h0, low, dst, {(CMD_W-OP_W){1'b0}}, op};
    endfunction

    task automatic drive_wait_in();
        integer r;
        r = $random(seed);
        wait_in = r[0];
    endtask

    task automatic apply_reset();
        rst_n     = 1'b0;
        access_in = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        check_level("wait_out after reset", wait_out, 1'b0);
        check_level("access_out after reset", access_out, 1'b0);
        check_level("err_out after reset", err_out, 1'b0);
    endtask

    task automatic send_write(input logic [AW-1:0] dst, input logic [WORD_W-1:0] data);
        check_level("wait_out before write", wait_out, 1'b0);
        access_in = 1'b1;
        packet_in = build_packet(OP_WRITE, dst, '0, data);
        drive_wait_in();
        @(negedge clk);
        check_level("wait_out after write", wait_out, 1'b0);  // next write may follow at once
    endtask

    task automatic check_response(input logic [AW-1:0] src, input logic [WORD_W-1:0] exp_word);
        check_level("access_out while responding", access_out, 1'b1);
        check_level("wait_out while responding", wait_out, 1'b1);
        check_op("response opcode", emesh_op_e'(packet_out[OP_W-1:0]), OP_RESP);
        check_addr("response dstaddr", packet_out[CMD_W+AW-1:CMD_W], src);
        check_word("response word", packet_out[79:48], exp_word);
        check_word("response upper data", packet_out[111:80], '0);
    endtask

    task automatic send_read(input logic [AW-1:0] dst, input logic [AW-1:0] src,
                             input logic [WORD_W-1:0] exp_word);
        int cycles;
        check_level("wait_out before read", wait_out, 1'b0);
        access_in = 1'b1;
        packet_in = build_packet(OP_READ, dst, src, '0);
        drive_wait_in();
        @(negedge clk);  // one edge past the accept
        packet_in = build_packet(OP_WRITE, STRAY_ADDR, '0, STRAY_DATA);
        cycles = 0;
        while (!access_out) begin
            check_level("wait_out during read latency", wait_out, 1'b1);
            if (cycles > TIMEOUT) report_timeout("read response");
            drive_wait_in();
            @(negedge clk);
            cycles++;
        end
        check_count("edges from accept to access_out", cycles, READ_WAIT + 1);
        check_response(src, exp_word);
        drive_wait_in();
        cycles = 0;
        while (wait_in) begin
            if (cycles > TIMEOUT) report_timeout("response handover");
            @(negedge clk);
            cycles++;
            check_response(src, exp_word);  // must hold under back-pressure
            drive_wait_in();
        end
        @(negedge clk);  // handover edge has passed
        access_in = 1'b0;
        check_level("access_out after handover", access_out, 1'b0);
        check_level("wait_out after handover", wait_out, 1'b0);
    endtask

    // unknown opcodes and inbound responses, neither may answer
    task automatic send_other(input logic [OP_W-1:0] op, input logic [AW-1:0] dst,
                              input logic [WORD_W-1:0] data, input logic exp_err);
        check_level("wait_out before command", wait_out, 1'b0);
        access_in = 1'b1;
        packet_in = build_packet(op, dst, '0, data);
        drive_wait_in();
        @(negedge clk);
        access_in = 1'b0;
        check_level("err_out after command", err_out, exp_err);
        check_level("wait_out after dropped command", wait_out, 1'b0);
        repeat (READ_WAIT + 2) begin
            check_level("access_out after dropped command", access_out, 1'b0);
            @(negedge clk);
        end
    endtask

    // ########################################################################
    // main sequence
    // ########################################################################
    initial begin
        int                fd;
        int                vectors;
        string             line;
        logic [OP_W-1:0]   op;
        logic [AW-1:0]     dst;
        logic [AW-1:0]     src;
        logic [WORD_W-1:0] data;
        logic [WORD_W-1:0] exp_word;
        logic              exp_err;

        rst_n     = 1'b0;
        access_in = 1'b0;
        packet_in = '0;
        wait_in   = 1'b0;
        exp_err   = 1'b0;
        vectors   = 0;
        apply_reset();

        fd = $fopen("tb/endpoint_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/endpoint_input.txt");
            stop_run();
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0 &&
                $sscanf(line, "%h %h %h %h %h %h", op, dst, src, data, exp_word, exp_err) == 6) begin
                case (emesh_op_e'(op))
                    OP_WRITE: send_write(dst, data);
                    OP_READ:  send_read(dst, src, exp_word);
                    default:  send_other(op, dst, data, exp_err);
                endcase
                check_level("err_out", err_out, exp_err);
                vectors++;
            end
        end
        $fclose(fd);
        access_in = 1'b0;
        if (vectors == 0) begin
            $display("the stimulus file held no vectors");
            stop_run();
        end

        // sticky error survives idle cycles, then only reset clears it
        repeat (4) @(negedge clk);
        check_level("err_out after idle cycles", err_out, exp_err);
        apply_reset();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/emesh_endpoint.sv
// emesh memory endpoint top; AW fixed at 32, PW 80 or 112, not pipelined so reads stay ordered
`default_nettype none

module emesh_endpoint #(
    parameter int AW        = 32,
    parameter int PW        = 112,
    parameter int MEM_DEPTH = 16,
    parameter int READ_WAIT = 3
) (
    input  wire logic          clk,
    input  wire logic          rst_n,
    // request side
    input  wire logic          access_in,
    input  wire logic [PW-1:0] packet_in,
    output logic               wait_out,
    // response side
    output logic               access_out,
    output logic [PW-1:0]      packet_out,
    input  wire logic          wait_in,
    output logic               err_out
);
    logic accept_wr;
    logic accept_rd;
    logic load;
    logic done;
    logic rsp_load;

    emesh_if #(.AW(AW)) req_bus ();
    emesh_if #(.AW(AW)) rsp_bus ();

    packet2emesh #(.AW(AW), .PW(PW)) packet2emesh_inst (
        .packet_in (packet_in),
        .bus       (req_bus.src)
    );

    access_ctrl access_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .access_in  (access_in),
        .req        (req_bus.snk),
        .wait_out   (wait_out),
        .accept_wr  (accept_wr),
        .accept_rd  (accept_rd),
        .load       (load),
        .done       (done),
        .rsp_load   (rsp_load),
        .access_out (access_out),
        .wait_in    (wait_in),
        .err_out    (err_out)
    );

    wait_timer #(.READ_WAIT(READ_WAIT)) wait_timer_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (load),
        .done  (done)
    );

    reg_mem #(.AW(AW), .PW(PW), .MEM_DEPTH(MEM_DEPTH)) reg_mem_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req_bus.snk),
        .accept_wr (accept_wr),
        .accept_rd (accept_rd),
        .rsp_load  (rsp_load),
        .rsp       (rsp_bus.src)
    );

    emesh2packet #(.AW(AW), .PW(PW)) emesh2packet_inst (
        .bus        (rsp_bus.snk),
        .packet_out (packet_out)
    );

endmodule

`default_nettype wire

//--- logic/reg_mem.sv
// word memory, index is dstaddr above bit 1 modulo MEM_DEPTH (power of two, >= 2); contents power up unknown
`default_nettype none

module reg_mem #(
    parameter int AW        = 32,
    parameter int PW        = 112,
    parameter int MEM_DEPTH = 16
) (
    input  wire logic clk,
    input  wire logic rst_n,
    emesh_if.snk      req,
    input  wire logic accept_wr,
    input  wire logic accept_rd,
    input  wire logic rsp_load,
    emesh_if.src      rsp
);
    import emesh_pkg::*;

    localparam int IDX_W = $clog2(MEM_DEPTH);

    logic [WORD_W-1:0] mem [MEM_DEPTH];
    logic [IDX_W-1:0]  idx;
    logic [IDX_W-1:0]  rd_idx;    // latched read index
    logic [AW-1:0]     ret_addr;  // latched return address

    assign idx = req.dstaddr[IDX_W+1:2];  // upper bits alias

    always_ff @(posedge clk) begin
        if (accept_wr) mem[idx] <= req.data[WORD_W-1:0];
        if (accept_rd) begin
            rd_idx   <= idx;
            ret_addr <= req.srcaddr;
        end
    end

    // ########################################################################
    // response bundle, word placement follows the packet layout
    // ########################################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp.cmd     <= '0;
            rsp.dstaddr <= '0;
            rsp.srcaddr <= '0;
            rsp.data    <= '0;
        end else if (rsp_load) begin
            rsp.cmd     <= CMD_W'(OP_RESP);
            rsp.dstaddr <= ret_addr;
            if (PW == 80) begin
                rsp.srcaddr <= AW'(mem[rd_idx]);  // short packet has no data field
                rsp.data    <= '0;
            end else begin
                rsp.srcaddr <= '0;
                rsp.data    <= (2*AW)'(mem[rd_idx]);
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/wait_timer.sv
// read latency counter; READ_WAIT must be at least 1 and load only comes once done is high
`default_nettype none

module wait_timer #(
    parameter int READ_WAIT = 3
) (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic load,
    output logic      done
);
    localparam int CNT_W = $clog2(READ_WAIT + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt <= '0;  // idle reads as done
        end else if (load) begin
            cnt <= CNT_W'(READ_WAIT);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign done = (cnt == '0);  // level until next load

    // controller only starts a read after the last one expired
    a_no_reload: assert property (@(posedge clk) disable iff (!rst_n)
        load |-> cnt == '0);

endmodule

`default_nettype wire

//--- logic/access_ctrl.sv
// controller for one request in flight; inbound OP_RESP is dropped, err_out clears only on reset
`default_nettype none

module access_ctrl (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic access_in,
    emesh_if.snk      req,
    output logic      wait_out,
    output logic      accept_wr,
    output logic      accept_rd,
    output logic      load,
    input  wire logic done,
    output logic      rsp_load,
    output logic      access_out,
    input  wire logic wait_in,
    output logic      err_out
);
    import emesh_pkg::*;

    ctrl_state_e state;
    emesh_op_e   op;
    logic        accept;
    logic        err_q;

    assign op     = emesh_op_e'(req.cmd[OP_W-1:0]);
    assign accept = access_in && rst_n && (state == ST_IDLE);

    assign accept_wr  = accept && (op == OP_WRITE);
    assign accept_rd  = accept && (op == OP_READ);
    assign load       = accept_rd;                          // start latency timer
    assign rsp_load   = (state == ST_READ_WAIT) && done;
    assign access_out = (state == ST_RESPOND);
    assign wait_out   = (state != ST_IDLE);
    assign err_out    = err_q;

    // ########################################################################
    // state machine
    // ########################################################################
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            err_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        case (op)
                            OP_READ:  state <= ST_READ_WAIT;
                            OP_WRITE: state <= ST_IDLE;  // done at this edge
                            OP_RESP:  state <= ST_IDLE;  // not ours, dropped
                            default:  err_q <= 1'b1;     // unknown, sticky
                        endcase
                    end
                end
                ST_READ_WAIT: if (done) state <= ST_RESPOND;
                ST_RESPOND:   if (!wait_in) state <= ST_IDLE;  // handover
                default:      state <= ST_IDLE;
            endcase
        end
    end

    // response must not vanish under back-pressure
    a_hold_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        access_out && wait_in |=> access_out);

endmodule

`default_nettype wire

//--- packet/emesh2packet.sv
// combinational packet encoder for response bundles; AW=32 with PW 80 or 112 only
`default_nettype none

module emesh2packet #(
    parameter int AW = 32,
    parameter int PW = 112
) (
    emesh_if.snk                bus,
    output logic [PW-1:0]       packet_out
);
    import emesh_pkg::*;

    generate
        if (AW == 32 && PW == 80) begin : g_p80
            // word travels in the srcaddr field, data is not carried
            assign packet_out[CMD_W-1:0]      = bus.cmd;
            assign packet_out[47:CMD_W]       = bus.dstaddr;
            assign packet_out[79:48]          = bus.srcaddr;
        end else if (AW == 32 && PW == 112) begin : g_p112
            // srcaddr field is overlaid by the low data word
            assign packet_out[CMD_W-1:0]      = bus.cmd;
            assign packet_out[47:CMD_W]       = bus.dstaddr;
            assign packet_out[111:48]         = bus.data;
        end else begin : g_bad_pw
            $fatal(1, "emesh2packet: AW=%0d PW=%0d not supported, use AW 32 with PW 80 or 112",
                   AW, PW);
        end
    endgenerate

endmodule

`default_nettype wire

//--- packet/packet2emesh.sv
// combinational packet decoder; only AW=32 with PW 80 or 112, other widths stop elaboration
`default_nettype none

module packet2emesh #(
    parameter int AW = 32,
    parameter int PW = 112
) (
    input  wire logic [PW-1:0] packet_in,
    emesh_if.src               bus
);
    import emesh_pkg::*;

    // ########################################################################
    // command and destination, common to both layouts
    // ########################################################################
    assign bus.cmd     = packet_in[CMD_W-1:0];
    assign bus.dstaddr = packet_in[CMD_W+AW-1:CMD_W];  // bits 47:16

    generate
        if (AW == 32 && PW == 80) begin : g_p80
            // short layout, write data shares the srcaddr field
            assign bus.srcaddr = packet_in[79:48];
            assign bus.data    = {{AW{1'b0}}, packet_in[79:48]};
        end else if (AW == 32 && PW == 112) begin : g_p112
            // long layout, data low word overlaps srcaddr
            assign bus.srcaddr = packet_in[79:48];
            assign bus.data    = packet_in[111:48];
        end else begin : g_bad_pw
            $fatal(1, "packet2emesh: AW=%0d PW=%0d not supported, use AW 32 with PW 80 or 112",
                   AW, PW);
        end
    endgenerate

endmodule

`default_nettype wire

//--- common/emesh_if.sv
// emesh bundle between endpoint blocks; AW must match the packet layout in use (32 here)
`default_nettype none

interface emesh_if #(
    parameter int AW = 32
);
    import emesh_pkg::*;

    logic [CMD_W-1:0] cmd;      // opcode in low bits
    logic [AW-1:0]    dstaddr;  // target address
    logic [AW-1:0]    srcaddr;  // return address
    logic [2*AW-1:0]  data;     // payload

    // driving side
    modport src (
        output cmd, dstaddr, srcaddr, data
    );

    // receiving side
    modport snk (
        input cmd, dstaddr, srcaddr, data
    );

endinterface

`default_nettype wire

//--- common/emesh_pkg.sv
// shared emesh widths and enums; the opcode sits in cmd[3:0] and the upper cmd bits carry no meaning here
`default_nettype none

package emesh_pkg;

    // ########################################################################
    // field widths
    // ########################################################################
    parameter int CMD_W  = 16;  // one emesh command word
    parameter int WORD_W = 32;  // memory word
    parameter int OP_W   = 4;   // opcode field in the command

    // ########################################################################
    // opcodes, low command bits
    // ########################################################################
    // every other code is unknown and flagged by the controller
    typedef enum logic [OP_W-1:0] {
        OP_READ  = 4'h0,  // read request, answered with OP_RESP
        OP_WRITE = 4'h1,  // single word write
        OP_RESP  = 4'h2   // read response
    } emesh_op_e;

    // ########################################################################
    // controller states
    // ########################################################################
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,  // ready for a request
        ST_READ_WAIT = 2'd1,  // slow memory latency
        ST_RESPOND   = 2'd2   // response held until taken
    } ctrl_state_e;

endpackage

`default_nettype wire
